/* source/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    localparam word_t resetPc = 32'hBFC0_0000;  // boot ROM entry

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opJ       = 6'b000010;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;

    // ALU_ADD is zero so a bubble decodes to a harmless add
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwdSel_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        word_t    pc;
        regAddr_t rsAddr;        // zero when rs is not a source
        regAddr_t rtAddr;
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        word_t    branchTarget;
        aluOp_t   aluOp;
        logic     useImm;
        logic     isBranch;
        logic     branchOnEqual; // beq vs bne
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        regAddr_t dest;
    } idEx_t;

    typedef struct packed {
        word_t    pc;
        word_t    aluResult;     // also the load/store address
        word_t    storeData;
        regAddr_t dest;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } exMem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        regAddr_t dest;
        logic     regWrite;
    } memWb_t;

endpackage

/* source/stageReg.sv */
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN_i,
    input  logic     en_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload is a bubble, no write and no memory access
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            q_o <= payload_t'('0);
        end else if (en_i) begin
            if (flush_i) begin
                q_o <= payload_t'('0);
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

/* source/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic           clk,
    input  logic           rstN_i,
    input  logic           hold_i,
    input  logic           jumpTaken_i,
    input  mipsPkg::word_t jumpTarget_i,
    input  logic           branchTaken_i,
    input  mipsPkg::word_t branchTarget_i,
    output mipsPkg::word_t pc_o
);

    mipsPkg::word_t nextPc;

    // branch in EX is older than the jump in ID, so it wins
    always_comb begin
        if (branchTaken_i) begin
            nextPc = branchTarget_i;
        end else if (jumpTaken_i) begin
            nextPc = jumpTarget_i;
        end else begin
            nextPc = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc_o <= mipsPkg::resetPc;
        end else if (!hold_i) begin
            pc_o <= nextPc;  // held on freeze and load-use
        end
    end

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  mipsPkg::ifId_t    ifId_i,
    input  mipsPkg::word_t    rsData_i,
    input  mipsPkg::word_t    rtData_i,
    output mipsPkg::regAddr_t rsAddr_o,
    output mipsPkg::regAddr_t rtAddr_o,
    output logic              jumpTaken_o,
    output mipsPkg::word_t    jumpTarget_o,
    output mipsPkg::idEx_t    idEx_o
);

    logic [5:0]        opcode, funct;
    mipsPkg::regAddr_t rs, rt, rd;
    mipsPkg::word_t    slotPc, immSext;
    logic              usesRs, usesRt, signExt;

    assign opcode  = ifId_i.instr[31:26];
    assign funct   = ifId_i.instr[5:0];
    assign rs      = ifId_i.instr[25:21];
    assign rt      = ifId_i.instr[20:16];
    assign rd      = ifId_i.instr[15:11];
    assign slotPc  = ifId_i.pc + 32'd4;  // pc of the delay slot
    assign immSext = {{16{ifId_i.instr[15]}}, ifId_i.instr[15:0]};

    always_comb begin
        idEx_o      = '0;
        usesRs      = 1'b0;
        usesRt      = 1'b0;
        signExt     = 1'b1;
        jumpTaken_o = 1'b0;
        unique case (opcode)
            mipsPkg::opSpecial: begin
                usesRs          = 1'b1;
                usesRt          = 1'b1;
                idEx_o.regWrite = 1'b1;
                idEx_o.dest     = rd;
                case (funct)
                    mipsPkg::fnAddu: idEx_o.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::fnSubu: idEx_o.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::fnAnd:  idEx_o.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::fnOr:   idEx_o.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::fnXor:  idEx_o.aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::fnSlt:  idEx_o.aluOp = mipsPkg::ALU_SLT;
                    default: begin
                        usesRs          = 1'b0;  // unknown funct, nop
                        usesRt          = 1'b0;
                        idEx_o.regWrite = 1'b0;
                    end
                endcase
            end
            mipsPkg::opAddiu, mipsPkg::opOri, mipsPkg::opLui, mipsPkg::opLw: begin
                usesRs          = (opcode != mipsPkg::opLui);
                signExt         = (opcode != mipsPkg::opOri);
                idEx_o.useImm   = 1'b1;
                idEx_o.regWrite = 1'b1;
                idEx_o.memRead  = (opcode == mipsPkg::opLw);
                idEx_o.dest     = rt;
                if (opcode == mipsPkg::opOri) begin
                    idEx_o.aluOp = mipsPkg::ALU_OR;
                end else if (opcode == mipsPkg::opLui) begin
                    idEx_o.aluOp = mipsPkg::ALU_LUI;
                end
            end
            mipsPkg::opSw: begin
                usesRs          = 1'b1;
                usesRt          = 1'b1;  // store data
                idEx_o.useImm   = 1'b1;
                idEx_o.memWrite = 1'b1;
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                usesRs               = 1'b1;
                usesRt               = 1'b1;
                idEx_o.isBranch      = 1'b1;
                idEx_o.branchOnEqual = (opcode == mipsPkg::opBeq);
            end
            mipsPkg::opJ: jumpTaken_o = 1'b1;
            default: ;  // outside the subset, nop
        endcase

        idEx_o.pc           = ifId_i.pc;
        idEx_o.rsAddr       = rsAddr_o;
        idEx_o.rtAddr       = rtAddr_o;
        idEx_o.rsData       = rsData_i;
        idEx_o.rtData       = rtData_i;
        idEx_o.imm          = signExt ? immSext : {16'b0, ifId_i.instr[15:0]};
        idEx_o.branchTarget = slotPc + {immSext[29:0], 2'b00};
    end

    // unused source fields read as $0 so no false forwarding or interlock
    assign rsAddr_o     = usesRs ? rs : '0;
    assign rtAddr_o     = usesRt ? rt : '0;
    assign jumpTarget_o = {slotPc[31:28], ifId_i.instr[25:0], 2'b00};

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic              we_i,
    input  mipsPkg::regAddr_t waddr_i,
    input  mipsPkg::word_t    wdata_i,
    input  mipsPkg::regAddr_t raddr1_i,
    input  mipsPkg::regAddr_t raddr2_i,
    output mipsPkg::word_t    rdata1_o,
    output mipsPkg::word_t    rdata2_o
);

    mipsPkg::word_t regs [1:31];  // $0 has no storage

    always_ff @(posedge clk) begin
        if (rstN_i && we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so WB and ID can share a cycle
    function automatic mipsPkg::word_t readPort(mipsPkg::regAddr_t addr);
        if (addr == '0) return '0;
        if (we_i && addr == waddr_i) return wdata_i;
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = readPort(raddr1_i);
        rdata2_o = readPort(raddr2_i);
    end

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  mipsPkg::idEx_t   idEx_i,
    input  mipsPkg::fwdSel_t fwdA_i,
    input  mipsPkg::fwdSel_t fwdB_i,
    input  mipsPkg::word_t   memResult_i,
    input  mipsPkg::word_t   wbResult_i,
    output logic             branchTaken_o,
    output mipsPkg::word_t   branchTarget_o,
    output mipsPkg::exMem_t  exMem_o
);

    mipsPkg::word_t opA, opB, aluB, aluResult;

    function automatic mipsPkg::word_t pickOperand(mipsPkg::fwdSel_t sel,
                                                   mipsPkg::word_t regVal);
        case (sel)
            mipsPkg::FWD_MEM: return memResult_i;
            mipsPkg::FWD_WB:  return wbResult_i;
            default:          return regVal;
        endcase
    endfunction

    always_comb begin
        opA = pickOperand(fwdA_i, idEx_i.rsData);
        opB = pickOperand(fwdB_i, idEx_i.rtData);
    end

    assign aluB = idEx_i.useImm ? idEx_i.imm : opB;

    always_comb begin
        case (idEx_i.aluOp)
            mipsPkg::ALU_SUB: aluResult = opA - aluB;
            mipsPkg::ALU_AND: aluResult = opA & aluB;
            mipsPkg::ALU_OR:  aluResult = opA | aluB;
            mipsPkg::ALU_XOR: aluResult = opA ^ aluB;
            mipsPkg::ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(aluB)};
            mipsPkg::ALU_LUI: aluResult = {aluB[15:0], 16'b0};
            default:          aluResult = opA + aluB;  // addu, addiu, address
        endcase
    end

    // compare uses forwarded registers and never the immediate
    assign branchTaken_o  = idEx_i.isBranch & ((opA == opB) == idEx_i.branchOnEqual);
    assign branchTarget_o = idEx_i.branchTarget;

    assign exMem_o = '{pc:        idEx_i.pc,
                       aluResult: aluResult,
                       storeData: opB,
                       dest:      idEx_i.dest,
                       regWrite:  idEx_i.regWrite,
                       memRead:   idEx_i.memRead,
                       memWrite:  idEx_i.memWrite};

endmodule

/* source/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  logic              iStall_i,
    input  logic              dStall_i,
    input  mipsPkg::regAddr_t rsAddrId_i,
    input  mipsPkg::regAddr_t rtAddrId_i,
    input  mipsPkg::idEx_t    idEx_i,
    input  mipsPkg::exMem_t   exMem_i,
    input  mipsPkg::memWb_t   memWb_i,
    input  logic              branchTaken_i,
    output logic              freeze_o,
    output logic              holdFront_o,
    output logic              flushIfId_o,
    output logic              flushIdEx_o,
    output mipsPkg::fwdSel_t  fwdA_o,
    output mipsPkg::fwdSel_t  fwdB_o
);

    logic loadUse;

    // youngest producer first
    function automatic mipsPkg::fwdSel_t fwdFor(mipsPkg::regAddr_t src);
        if (src == '0) return mipsPkg::FWD_REG;
        if (exMem_i.regWrite && exMem_i.dest == src) return mipsPkg::FWD_MEM;
        if (memWb_i.regWrite && memWb_i.dest == src) return mipsPkg::FWD_WB;
        return mipsPkg::FWD_REG;
    endfunction

    always_comb begin
        fwdA_o = fwdFor(idEx_i.rsAddr);
        fwdB_o = fwdFor(idEx_i.rtAddr);
    end

    // load data only exists in MEM so one bubble lets WB forward it
    assign loadUse = idEx_i.memRead && idEx_i.dest != '0 &&
                     (idEx_i.dest == rsAddrId_i || idEx_i.dest == rtAddrId_i);

    assign freeze_o    = iStall_i | dStall_i;
    assign holdFront_o = freeze_o | loadUse;
    assign flushIdEx_o = loadUse & ~freeze_o;
    assign flushIfId_o = branchTaken_i & ~freeze_o;  // delay slot in ID survives

endmodule

/* source/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
    input  logic              clk,
    input  logic              rstN_i,
    input  mipsPkg::word_t    instr_i,
    input  logic              iStall_i,
    input  mipsPkg::word_t    memRdata_i,
    input  logic              dStall_i,
    output mipsPkg::word_t    instAddr_o,
    output logic              instEn_o,
    output logic              memEn_o,
    output logic [3:0]        memWen_o,
    output mipsPkg::word_t    memAddr_o,
    output mipsPkg::word_t    memWdata_o,
    output mipsPkg::word_t    debugWbPc_o,
    output mipsPkg::regAddr_t debugWbRfWnum_o,
    output logic [3:0]        debugWbRfWen_o,
    output mipsPkg::word_t    debugWbRfWdata_o
);

    mipsPkg::word_t    pc, rsData, rtData, jumpTarget, branchTarget, memResult;
    mipsPkg::regAddr_t rsAddr, rtAddr;
    logic              jumpTaken, branchTaken;
    logic              freeze, holdFront, flushIfId, flushIdEx, wbWe;
    mipsPkg::fwdSel_t  fwdA, fwdB;

    mipsPkg::ifId_t  ifIdD, ifIdQ;
    mipsPkg::idEx_t  idExD, idExQ;
    mipsPkg::exMem_t exMemD, exMemQ;
    mipsPkg::memWb_t memWbD, memWbQ;

    fetchUnit fetch (.clk, .rstN_i, .hold_i(holdFront), .jumpTaken_i(jumpTaken),
        .jumpTarget_i(jumpTarget), .branchTaken_i(branchTaken),
        .branchTarget_i(branchTarget), .pc_o(pc));

    assign instAddr_o = pc;
    assign instEn_o   = 1'b1;  // fetch every cycle, stalls come back on iStall_i
    assign ifIdD      = '{pc: pc, instr: instr_i};

    stageReg #(.payload_t(mipsPkg::ifId_t)) ifIdReg (.clk, .rstN_i,
        .en_i(~holdFront), .flush_i(flushIfId), .d_i(ifIdD), .q_o(ifIdQ));

    decoder dec (.ifId_i(ifIdQ), .rsData_i(rsData), .rtData_i(rtData),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .jumpTaken_o(jumpTaken),
        .jumpTarget_o(jumpTarget), .idEx_o(idExD));

    assign wbWe = memWbQ.regWrite & ~freeze;

    regFile rf (.clk, .rstN_i, .we_i(wbWe), .waddr_i(memWbQ.dest),
        .wdata_i(memWbQ.result), .raddr1_i(rsAddr), .raddr2_i(rtAddr),
        .rdata1_o(rsData), .rdata2_o(rtData));

    stageReg #(.payload_t(mipsPkg::idEx_t)) idExReg (.clk, .rstN_i,
        .en_i(~freeze), .flush_i(flushIdEx), .d_i(idExD), .q_o(idExQ));

    executeUnit ex (.idEx_i(idExQ), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memResult_i(exMemQ.aluResult), .wbResult_i(memWbQ.result),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .exMem_o(exMemD));

    stageReg #(.payload_t(mipsPkg::exMem_t)) exMemReg (.clk, .rstN_i,
        .en_i(~freeze), .flush_i(1'b0), .d_i(exMemD), .q_o(exMemQ));

    // memory stage
    assign memEn_o    = exMemQ.memRead | exMemQ.memWrite;
    assign memWen_o   = {4{exMemQ.memWrite}};  // word stores only
    assign memAddr_o  = exMemQ.aluResult;
    assign memWdata_o = exMemQ.storeData;
    assign memResult  = exMemQ.memRead ? memRdata_i : exMemQ.aluResult;
    assign memWbD     = '{pc: exMemQ.pc, result: memResult, dest: exMemQ.dest,
                          regWrite: exMemQ.regWrite};

    stageReg #(.payload_t(mipsPkg::memWb_t)) memWbReg (.clk, .rstN_i,
        .en_i(~freeze), .flush_i(1'b0), .d_i(memWbD), .q_o(memWbQ));

    hazardUnit hz (.iStall_i, .dStall_i, .rsAddrId_i(rsAddr), .rtAddrId_i(rtAddr),
        .idEx_i(idExQ), .exMem_i(exMemQ), .memWb_i(memWbQ), .branchTaken_i(branchTaken),
        .freeze_o(freeze), .holdFront_o(holdFront), .flushIfId_o(flushIfId),
        .flushIdEx_o(flushIdEx), .fwdA_o(fwdA), .fwdB_o(fwdB));

    // writeback trace, writes to $0 are not reported
    assign debugWbPc_o      = memWbQ.pc;
    assign debugWbRfWnum_o  = memWbQ.dest;
    assign debugWbRfWdata_o = memWbQ.result;
    assign debugWbRfWen_o   = {4{wbWe & (memWbQ.dest != '0)}};

endmodule

/* testbench/mipsRefModel.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// random R-type, all fields from $0..$15
function automatic logic [31:0] randAlu();
    logic [5:0] fns [0:5];
    fns = '{mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd,
            mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnSlt};
    return {mipsPkg::opSpecial, pickReg(), pickReg(), pickReg(), 5'b0, fns[rnd() % 6]};
endfunction

function automatic void genProgram();
    logic [4:0]  r;
    logic [5:0]  op;
    logic [31:0] tgt;
    for (int i = 1; i < 16; i++) begin
        putInstr({mipsPkg::opLui, 5'd0, 5'(i), 16'(rnd())});
        putInstr({mipsPkg::opOri, 5'(i), 5'(i), 16'(rnd())});  // needs the lui result
    end
    putInstr({mipsPkg::opOri, 5'd0, 5'(baseReg), 16'h0100});  // data window base
    while (progLen < 240) begin
        r = pickReg();
        case (rnd() % 9)
            0, 1: putInstr(randAlu());
            2: putInstr({mipsPkg::opAddiu, pickReg(), r, 16'(rnd())});
            3: putInstr({mipsPkg::opOri, pickReg(), r, 16'(rnd())});
            4: putInstr({mipsPkg::opLui, 5'd0, r, 16'(rnd())});
            5: begin
                putInstr({mipsPkg::opLw, 5'(baseReg), r, memOffset()});
                putInstr({mipsPkg::opSpecial, r, pickReg(), pickReg(), 5'b0, mipsPkg::fnAddu});
            end
            6: putInstr({mipsPkg::opSw, 5'(baseReg), r, memOffset()});
            7: begin
                // offset 2 skips only the third slot when taken
                op = (rnd() % 2 == 0) ? mipsPkg::opBeq : mipsPkg::opBne;
                putInstr({op, r, (rnd() % 2 == 0) ? r : pickReg(), 16'd2});
                putInstr(randAlu());
                putInstr(randAlu());
            end
            default: begin
                tgt = mipsPkg::resetPc + 32'(4 * (progLen + 3));
                putInstr({mipsPkg::opJ, tgt[27:2]});
                putInstr(randAlu());  // delay slot
                putInstr(randAlu());  // never executed
            end
        endcase
    end
endfunction

// instruction-level model with one delay slot, fills the expected write list
function automatic void runReference();
    logic [31:0] regs [0:31];
    logic [31:0] mem [0:ramWords-1];
    logic [31:0] pc, npc, nnpc, ins, a, b, imm, val;
    logic [4:0]  dst;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < ramWords; i++) mem[i] = fillWord(i);
    pc  = mipsPkg::resetPc;
    npc = pc + 32'd4;
    while (((pc - mipsPkg::resetPc) >> 2) < progLen) begin
        ins  = prog[(pc - mipsPkg::resetPc) >> 2];
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        dst  = '0;
        val  = '0;
        nnpc = npc + 32'd4;
        case (ins[31:26])
            mipsPkg::opSpecial: begin
                dst = ins[15:11];
                case (ins[5:0])
                    mipsPkg::fnAddu: val = a + b;
                    mipsPkg::fnSubu: val = a - b;
                    mipsPkg::fnAnd:  val = a & b;
                    mipsPkg::fnOr:   val = a | b;
                    mipsPkg::fnXor:  val = a ^ b;
                    mipsPkg::fnSlt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         dst = '0;
                endcase
            end
            mipsPkg::opAddiu, mipsPkg::opOri, mipsPkg::opLui, mipsPkg::opLw: begin
                dst = ins[20:16];
                val = a + imm;  // addiu, also the load address
                if (ins[31:26] == mipsPkg::opOri) val = a | {16'b0, ins[15:0]};
                if (ins[31:26] == mipsPkg::opLui) val = {ins[15:0], 16'b0};
                if (ins[31:26] == mipsPkg::opLw) val = mem[val[9:2]];
            end
            mipsPkg::opSw: begin
                val = a + imm;
                mem[val[9:2]] = b;
            end
            mipsPkg::opBeq: nnpc = (a == b) ? npc + {imm[29:0], 2'b00} : nnpc;
            mipsPkg::opBne: nnpc = (a != b) ? npc + {imm[29:0], 2'b00} : nnpc;
            mipsPkg::opJ:   nnpc = {npc[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        if (dst != '0) begin
            regs[dst] = val;
            expPc.push_back(pc);
            expReg.push_back(dst);
            expVal.push_back(val);
        end
        pc  = npc;
        npc = nnpc;
    end
endfunction

`endif

/* testbench/tbMipsCore.sv */
`timescale 1ns/1ps

module tbMipsCore;

    localparam int romWords      = 512;
    localparam int ramWords      = 256;
    localparam int baseReg       = 28;  // data pointer and never a random dest
    localparam int timeoutCycles = 4000;

    logic              clk, rstN, iStall, dStall, instEn, memEn;
    logic [3:0]        memWen, dbgWen;
    mipsPkg::word_t    instr, memRdata, instAddr, memAddr, memWdata, dbgPc, dbgWdata;
    mipsPkg::regAddr_t dbgWnum;

    logic [31:0] prog [0:romWords-1];
    logic [31:0] dataRam [0:ramWords-1];
    logic [31:0] expPc [$];
    logic [4:0]  expReg [$];
    logic [31:0] expVal [$];
    logic [31:0] rngState, romIdx;
    int          progLen, expIdx, checkCount, errorCount;
    logic        checking, timedOut;

    mipsCore u_dut (
        .clk, .rstN_i(rstN), .instr_i(instr), .iStall_i(iStall), .memRdata_i(memRdata),
        .dStall_i(dStall), .instAddr_o(instAddr), .instEn_o(instEn), .memEn_o(memEn),
        .memWen_o(memWen), .memAddr_o(memAddr), .memWdata_o(memWdata), .debugWbPc_o(dbgPc),
        .debugWbRfWnum_o(dbgWnum), .debugWbRfWen_o(dbgWen), .debugWbRfWdata_o(dbgWdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign romIdx   = (instAddr - mipsPkg::resetPc) >> 2;
    assign instr    = (romIdx < romWords) ? prog[romIdx] : '0;  // nop past the program
    assign memRdata = memEn ? dataRam[memAddr[9:2]] : 'x;  // no data without an enable

    always @(posedge clk) begin
        if (memEn && memWen == 4'hF && !dStall) dataRam[memAddr[9:2]] <= memWdata;
    end

    function automatic logic [31:0] rnd();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(rnd() % 16);
    endfunction

    function automatic logic [15:0] memOffset();
        return 16'((rnd() % 16) * 4);  // small window so loads hit earlier stores
    endfunction

    function automatic logic [31:0] fillWord(int idx);
        return ((32'(idx) << 2) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic void putInstr(logic [31:0] ins);
        prog[progLen] = ins;
        progLen++;
    endfunction

    `include "mipsRefModel.svh"

    // every reported write must be the next one in program order
    always @(negedge clk) begin
        if (checking && dbgWen !== 4'h0) begin
            if (dbgWen !== 4'hF) begin
                errorCount++;
                $display("FAIL %0t: debugWbRfWen is %h", $time, dbgWen);
            end else if (expIdx >= expPc.size()) begin
                errorCount++;
                $display("unexpected extra register write at %0t: pc %h wrote $%0d",
                         $time, dbgPc, dbgWnum);
            end else begin
                checkCount++;
                if (dbgPc !== expPc[expIdx] || dbgWnum !== expReg[expIdx] ||
                    dbgWdata !== expVal[expIdx]) begin
                    errorCount++;
                    $display("FAIL %0t: write %0d is pc %h $%0d=%h, expected pc %h $%0d=%h",
                             $time, expIdx, dbgPc, dbgWnum, dbgWdata,
                             expPc[expIdx], expReg[expIdx], expVal[expIdx]);
                end
                expIdx++;
            end
        end
    end

    task automatic checkQuiet(input string where);
        if (memEn !== 1'b0 || memWen !== 4'h0 || dbgWen !== 4'h0) begin
            errorCount++;
            $display("FAIL %0t: %s, memEn %b memWen %h debugWbRfWen %h",
                     $time, where, memEn, memWen, dbgWen);
        end
    endtask

    // one run of the program from reset
    task automatic runPass(input logic withStalls);
        int cycle;
        for (int i = 0; i < ramWords; i++) dataRam[i] = fillWord(i);
        rstN     = 1'b0;
        iStall   = 1'b0;
        dStall   = 1'b0;
        checking = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        checkQuiet("bus activity during reset");
        expIdx   = 0;
        rstN     = 1'b1;
        checking = 1'b1;
        cycle    = 0;
        while (expIdx < expPc.size() && cycle < timeoutCycles) begin
            @(negedge clk);
            if (cycle == 0 && (instAddr !== mipsPkg::resetPc || instEn !== 1'b1)) begin
                errorCount++;
                $display("FAIL %0t: first fetch from %h, enable %b", $time, instAddr, instEn);
            end
            if (cycle < 3) checkQuiet("bus activity before the first instruction");
            @(posedge clk);
            #1;
            iStall = withStalls && (rnd() % 4 == 0);
            dStall = withStalls && (rnd() % 4 == 0);
            cycle++;
        end
        if (expIdx < expPc.size()) begin
            $display("timeout: run with stalls=%0b saw only %0d of %0d register writes",
                     withStalls, expIdx, expPc.size());
            errorCount++;
            timedOut = 1'b1;
        end
        iStall = 1'b0;
        dStall = 1'b0;
        repeat (20) @(posedge clk);  // drain so late writes count as extra
        #1;
        checking = 1'b0;
    endtask

    initial begin
        rngState   = 32'd60;
        progLen    = 0;
        checkCount = 0;
        errorCount = 0;
        timedOut   = 1'b0;
        for (int i = 0; i < romWords; i++) prog[i] = '0;
        genProgram();
        runReference();
        runPass(1'b0);
        if (!timedOut) runPass(1'b1);  // same trace expected under random stalls
        $display("register writes checked: %0d (%0d per run), errors: %0d",
                 checkCount, expPc.size(), errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
source/mipsPkg.sv
source/stageReg.sv
source/fetchUnit.sv
source/decoder.sv
source/regFile.sv
source/executeUnit.sv
source/hazardUnit.sv
source/mipsCore.sv
testbench/tbMipsCore.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - source/mipsPkg.sv
      - source/stageReg.sv
      - source/fetchUnit.sv
      - source/decoder.sv
      - source/regFile.sv
      - source/executeUnit.sv
      - source/hazardUnit.sv
      - source/mipsCore.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbMipsCore.sv
